// File: logic/dcache_pkg.sv
package dcache_pkg;

    // address split
    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int LINE_WIDTH     = 128;
    localparam int STRB_WIDTH     = 4;
    localparam int NWAY           = 2;
    localparam int NSET           = 16;
    localparam int OFFSET_WIDTH   = 4;
    localparam int INDEX_WIDTH    = 4;
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int WORD_SEL_WIDTH = 2;

    // write-back buffer
    localparam int WB_DEPTH     = 2;
    localparam int WB_PTR_WIDTH = $clog2(WB_DEPTH);

    // victim lfsr
    localparam int          LFSR_WIDTH = 16;
    localparam logic [15:0] LFSR_SEED  = 16'hace1;

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [STRB_WIDTH-1:0]     strb_t;
    typedef logic [LINE_WIDTH-1:0]     line_t;
    typedef logic [TAG_WIDTH-1:0]      tag_t;
    typedef logic [INDEX_WIDTH-1:0]    index_t;
    typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;
    typedef logic [NWAY-1:0]           way_sel_t;

    // 26-bit tag ram entry
    typedef struct packed {
        logic dirty;
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOK_UP,
        MISS_REQ,
        MISS_WAIT
    } cache_state_t;

endpackage

// File: logic/lfsr.sv
`timescale 1ns/1ps

module lfsr (
    input  logic                             clk,
    input  logic                             rst,
    output logic [dcache_pkg::LFSR_WIDTH-1:0] value_o
);

    logic feedback;

    // taps 16,14,13,11 give a maximal-length sequence
    assign feedback = value_o[15] ^ value_o[13] ^ value_o[12] ^ value_o[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            value_o <= dcache_pkg::LFSR_SEED;
        end else begin
            value_o <= {value_o[14:0], feedback};
        end
    end

endmodule

// File: logic/cache_ram.sv
`timescale 1ns/1ps

module cache_ram #(
    parameter type data_t = logic,
    parameter int  DEPTH  = 16
) (
    input  logic               clk,
    input  logic               en_i,
    input  logic               we_i,
    input  dcache_pkg::index_t addr_i,
    input  data_t              wdata_i,
    output data_t              rdata_o
);

    data_t mem [DEPTH];

    // read-first: a write returns the old entry
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_o <= mem[addr_i];
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
        end
    end

endmodule

// File: logic/store_merge.sv
`timescale 1ns/1ps

module store_merge (
    input  dcache_pkg::line_t     line_i,
    input  dcache_pkg::word_sel_t word_sel_i,
    input  dcache_pkg::strb_t     wstrb_i,
    input  dcache_pkg::word_t     wdata_i,
    output dcache_pkg::line_t     line_o
);

    always_comb begin
        line_o = line_i;
        for (int b = 0; b < dcache_pkg::STRB_WIDTH; b++) begin
            if (wstrb_i[b]) begin
                line_o[word_sel_i * dcache_pkg::WORD_WIDTH + b * 8 +: 8] = wdata_i[b * 8 +: 8];
            end
        end
    end

endmodule

// File: logic/wb_buffer.sv
`timescale 1ns/1ps

module wb_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              push_i,
    input  dcache_pkg::addr_t push_addr_i,
    input  dcache_pkg::line_t push_line_i,
    input  dcache_pkg::addr_t match_addr_i,
    output logic              match_o,
    output logic              empty_o,
    output logic              full_o,
    input  logic              pop_i,
    output dcache_pkg::addr_t head_addr_o,
    output dcache_pkg::line_t head_line_o
);

    dcache_pkg::addr_t                     addr_q [dcache_pkg::WB_DEPTH];
    dcache_pkg::line_t                     line_q [dcache_pkg::WB_DEPTH];
    logic [dcache_pkg::WB_DEPTH-1:0]       vld_q;
    logic [dcache_pkg::WB_PTR_WIDTH-1:0]   wr_ptr;
    logic [dcache_pkg::WB_PTR_WIDTH-1:0]   rd_ptr;

    assign empty_o     = ~|vld_q;
    assign full_o      = &vld_q;
    assign head_addr_o = addr_q[rd_ptr];
    assign head_line_o = line_q[rd_ptr];

    // compare line addresses only
    always_comb begin
        match_o = 1'b0;
        for (int i = 0; i < dcache_pkg::WB_DEPTH; i++) begin
            if (vld_q[i] && addr_q[i][dcache_pkg::ADDR_WIDTH-1:dcache_pkg::OFFSET_WIDTH]
                    == match_addr_i[dcache_pkg::ADDR_WIDTH-1:dcache_pkg::OFFSET_WIDTH]) begin
                match_o = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q  <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                vld_q[wr_ptr] <= 1'b1;
                wr_ptr <= (wr_ptr == dcache_pkg::WB_PTR_WIDTH'(dcache_pkg::WB_DEPTH - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                vld_q[rd_ptr] <= 1'b0;
                rd_ptr <= (rd_ptr == dcache_pkg::WB_PTR_WIDTH'(dcache_pkg::WB_DEPTH - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            addr_q[wr_ptr] <= push_addr_i;
            line_q[wr_ptr] <= push_line_i;
        end
    end

endmodule

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                    clk,
    input  logic                                    rst,
    // cpu side
    input  logic                                    valid_i,
    input  dcache_pkg::addr_t                       addr_i,
    input  dcache_pkg::strb_t                       wstrb_i,
    input  dcache_pkg::word_t                       wdata_i,
    output logic                                    data_ok_o,
    output dcache_pkg::word_t                       rdata_o,
    // tag and data rams
    input  dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0] tag_rdata_i,
    input  dcache_pkg::line_t [dcache_pkg::NWAY-1:0]      data_rdata_i,
    output logic                                    ram_en_o,
    output dcache_pkg::index_t                      ram_addr_o,
    output dcache_pkg::way_sel_t                    tag_we_o,
    output dcache_pkg::tag_entry_t                  tag_wdata_o,
    output dcache_pkg::way_sel_t                    data_we_o,
    output dcache_pkg::line_t                       data_wdata_o,
    // store merge
    output dcache_pkg::line_t                       merge_line_o,
    output dcache_pkg::word_sel_t                   merge_sel_o,
    output dcache_pkg::strb_t                       merge_strb_o,
    output dcache_pkg::word_t                       merge_wdata_o,
    input  dcache_pkg::line_t                       merge_line_i,
    input  logic                                    victim_bit_i,
    // write-back buffer
    output logic                                    wb_push_o,
    output dcache_pkg::addr_t                       wb_push_addr_o,
    output dcache_pkg::line_t                       wb_push_line_o,
    output dcache_pkg::addr_t                       wb_match_addr_o,
    input  logic                                    wb_match_i,
    input  logic                                    wb_empty_i,
    input  logic                                    wb_full_i,
    output logic                                    wb_pop_o,
    input  dcache_pkg::addr_t                       wb_head_addr_i,
    input  dcache_pkg::line_t                       wb_head_line_i,
    // memory port
    input  logic                                    mem_rdy_i,
    output logic                                    mem_req_o,
    output logic                                    mem_we_o,
    output dcache_pkg::addr_t                       mem_addr_o,
    output dcache_pkg::line_t                       mem_wdata_o,
    input  logic                                    mem_rvalid_i,
    input  dcache_pkg::line_t                       mem_rdata_i
);

    dcache_pkg::cache_state_t state, next_state;

    logic                   sweep_q;
    dcache_pkg::index_t     sweep_cnt;

    dcache_pkg::addr_t      req_addr;
    dcache_pkg::strb_t      req_strb;
    dcache_pkg::word_t      req_wdata;
    logic                   victim_q;

    dcache_pkg::tag_t       req_tag;
    dcache_pkg::index_t     req_index;
    dcache_pkg::word_sel_t  req_sel;
    logic                   is_store;

    dcache_pkg::way_sel_t   tag_hit;
    dcache_pkg::way_sel_t   victim_sel;
    dcache_pkg::tag_entry_t victim_entry;
    dcache_pkg::line_t      hit_line;
    logic                   hit;
    logic                   accept;
    logic                   lookup;
    logic                   refill;
    logic                   req_ok;
    logic                   drain;

    assign req_tag   = req_addr[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];
    assign req_index = req_addr[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
    assign req_sel   = req_addr[dcache_pkg::OFFSET_WIDTH-1 -: dcache_pkg::WORD_SEL_WIDTH];
    assign is_store  = |req_strb;

    always_comb begin
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            tag_hit[w] = tag_rdata_i[w].valid && tag_rdata_i[w].tag == req_tag;
        end
    end

    assign hit      = |tag_hit;
    assign hit_line = tag_hit[1] ? data_rdata_i[1] : data_rdata_i[0];

    assign victim_sel   = dcache_pkg::way_sel_t'(1) << victim_q;
    assign victim_entry = tag_rdata_i[victim_q];

    assign accept = state == dcache_pkg::IDLE && valid_i && !sweep_q;
    assign lookup = state == dcache_pkg::LOOK_UP;
    assign refill = state == dcache_pkg::MISS_WAIT && mem_rvalid_i;
    assign req_ok = state == dcache_pkg::MISS_REQ && mem_rdy_i && !wb_full_i && !wb_match_i;

    // a full or matching buffer has to drain before the refill request
    assign drain = mem_rdy_i && !wb_empty_i &&
                   ((state == dcache_pkg::IDLE && !valid_i) || (lookup && hit) ||
                    (state == dcache_pkg::MISS_REQ && (wb_full_i || wb_match_i)));

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::IDLE:      if (accept) next_state = dcache_pkg::LOOK_UP;
            dcache_pkg::LOOK_UP:   next_state = hit ? dcache_pkg::IDLE : dcache_pkg::MISS_REQ;
            dcache_pkg::MISS_REQ:  if (req_ok) next_state = dcache_pkg::MISS_WAIT;
            dcache_pkg::MISS_WAIT: if (mem_rvalid_i) next_state = dcache_pkg::IDLE;
            default:               next_state = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= dcache_pkg::IDLE;
            sweep_q   <= 1'b1;
            sweep_cnt <= '0;
        end else begin
            state <= next_state;
            if (sweep_q) begin
                sweep_cnt <= sweep_cnt + 1'b1;
                if (sweep_cnt == dcache_pkg::index_t'(dcache_pkg::NSET - 1)) begin
                    sweep_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= addr_i;
            req_strb  <= wstrb_i;
            req_wdata <= wdata_i;
        end
        if (lookup) begin
            victim_q <= victim_bit_i;
        end
    end

    // ram access: sweep, lookup read, store hit, refill
    always_comb begin
        ram_en_o     = 1'b0;
        ram_addr_o   = req_index;
        tag_we_o     = '0;
        tag_wdata_o  = '0;
        data_we_o    = '0;
        data_wdata_o = merge_line_i;
        if (sweep_q) begin
            ram_en_o   = 1'b1;
            ram_addr_o = sweep_cnt;
            tag_we_o   = '1;
        end else if (accept) begin
            ram_en_o   = 1'b1;
            ram_addr_o = addr_i[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
        end else if (lookup && hit && is_store) begin
            ram_en_o    = 1'b1;
            tag_we_o    = tag_hit;
            data_we_o   = tag_hit;
            tag_wdata_o = '{dirty: 1'b1, valid: 1'b1, tag: req_tag};
        end else if (refill) begin
            ram_en_o    = 1'b1;
            tag_we_o    = victim_sel;
            data_we_o   = victim_sel;
            tag_wdata_o = '{dirty: is_store, valid: 1'b1, tag: req_tag};
        end
    end

    assign merge_line_o  = (state == dcache_pkg::MISS_WAIT) ? mem_rdata_i : hit_line;
    assign merge_sel_o   = req_sel;
    assign merge_strb_o  = req_strb;
    assign merge_wdata_o = req_wdata;

    // ram outputs still hold the lookup read while waiting for the refill
    assign wb_push_o       = refill && victim_entry.valid && victim_entry.dirty;
    assign wb_push_addr_o  = {victim_entry.tag, req_index, {dcache_pkg::OFFSET_WIDTH{1'b0}}};
    assign wb_push_line_o  = data_rdata_i[victim_q];
    assign wb_match_addr_o = req_addr;
    assign wb_pop_o        = drain;

    assign mem_req_o   = drain || req_ok;
    assign mem_we_o    = drain;
    assign mem_addr_o  = drain ? wb_head_addr_i :
                         {req_tag, req_index, {dcache_pkg::OFFSET_WIDTH{1'b0}}};
    assign mem_wdata_o = wb_head_line_i;

    assign data_ok_o = (lookup && hit) || refill;
    assign rdata_o   = data_ok_o ?
                       merge_line_i[req_sel * dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH] :
                       '0;

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_i,
    input  dcache_pkg::addr_t addr_i,
    input  dcache_pkg::strb_t wstrb_i,
    input  dcache_pkg::word_t wdata_i,
    output logic              data_ok_o,
    output dcache_pkg::word_t rdata_o,
    input  logic              mem_rdy_i,
    output logic              mem_req_o,
    output logic              mem_we_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::line_t mem_wdata_o,
    input  logic              mem_rvalid_i,
    input  dcache_pkg::line_t mem_rdata_i
);

    dcache_pkg::tag_entry_t [dcache_pkg::NWAY-1:0] tag_rdata;
    dcache_pkg::line_t [dcache_pkg::NWAY-1:0]      data_rdata;

    logic                             ram_en;
    dcache_pkg::index_t               ram_addr;
    dcache_pkg::way_sel_t             tag_we;
    dcache_pkg::tag_entry_t           tag_wdata;
    dcache_pkg::way_sel_t             data_we;
    dcache_pkg::line_t                data_wdata;
    dcache_pkg::line_t                merge_in;
    dcache_pkg::line_t                merge_out;
    dcache_pkg::word_sel_t            merge_sel;
    dcache_pkg::strb_t                merge_strb;
    dcache_pkg::word_t                merge_wdata;
    logic [dcache_pkg::LFSR_WIDTH-1:0] lfsr_value;
    logic                             wb_push;
    dcache_pkg::addr_t                wb_push_addr;
    dcache_pkg::line_t                wb_push_line;
    dcache_pkg::addr_t                wb_match_addr;
    logic                             wb_match;
    logic                             wb_empty;
    logic                             wb_full;
    logic                             wb_pop;
    dcache_pkg::addr_t                wb_head_addr;
    dcache_pkg::line_t                wb_head_line;

    dcache_ctrl u_ctrl (
        .clk, .rst,
        .valid_i, .addr_i, .wstrb_i, .wdata_i, .data_ok_o, .rdata_o,
        .tag_rdata_i     (tag_rdata),
        .data_rdata_i    (data_rdata),
        .ram_en_o        (ram_en),
        .ram_addr_o      (ram_addr),
        .tag_we_o        (tag_we),
        .tag_wdata_o     (tag_wdata),
        .data_we_o       (data_we),
        .data_wdata_o    (data_wdata),
        .merge_line_o    (merge_in),
        .merge_sel_o     (merge_sel),
        .merge_strb_o    (merge_strb),
        .merge_wdata_o   (merge_wdata),
        .merge_line_i    (merge_out),
        .victim_bit_i    (lfsr_value[0]),
        .wb_push_o       (wb_push),
        .wb_push_addr_o  (wb_push_addr),
        .wb_push_line_o  (wb_push_line),
        .wb_match_addr_o (wb_match_addr),
        .wb_match_i      (wb_match),
        .wb_empty_i      (wb_empty),
        .wb_full_i       (wb_full),
        .wb_pop_o        (wb_pop),
        .wb_head_addr_i  (wb_head_addr),
        .wb_head_line_i  (wb_head_line),
        .mem_rdy_i, .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o,
        .mem_rvalid_i, .mem_rdata_i
    );

    for (genvar w = 0; w < dcache_pkg::NWAY; w++) begin : g_way
        cache_ram #(
            .data_t (dcache_pkg::tag_entry_t),
            .DEPTH  (dcache_pkg::NSET)
        ) u_tag_ram (
            .clk, .en_i(ram_en), .we_i(tag_we[w]), .addr_i(ram_addr),
            .wdata_i(tag_wdata), .rdata_o(tag_rdata[w])
        );
        cache_ram #(
            .data_t (dcache_pkg::line_t),
            .DEPTH  (dcache_pkg::NSET)
        ) u_data_ram (
            .clk, .en_i(ram_en), .we_i(data_we[w]), .addr_i(ram_addr),
            .wdata_i(data_wdata), .rdata_o(data_rdata[w])
        );
    end

    store_merge u_merge (
        .line_i(merge_in), .word_sel_i(merge_sel), .wstrb_i(merge_strb),
        .wdata_i(merge_wdata), .line_o(merge_out)
    );

    wb_buffer u_wb (
        .clk, .rst,
        .push_i(wb_push), .push_addr_i(wb_push_addr), .push_line_i(wb_push_line),
        .match_addr_i(wb_match_addr), .match_o(wb_match),
        .empty_o(wb_empty), .full_o(wb_full), .pop_i(wb_pop),
        .head_addr_o(wb_head_addr), .head_line_o(wb_head_line)
    );

    lfsr u_lfsr (
        .clk, .rst, .value_o(lfsr_value)
    );

endmodule

// File: bench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int                N_OPS      = 800;
    localparam int                WAIT_LIMIT = 200;
    localparam dcache_pkg::addr_t BASE_ADDR  = 32'h0012_3000;

    logic                      clk;
    logic                      rst;
    logic                      valid_i;
    dcache_pkg::addr_t         addr_i;
    dcache_pkg::strb_t         wstrb_i;
    dcache_pkg::word_t         wdata_i;
    logic                      data_ok_o;
    dcache_pkg::word_t         rdata_o;
    logic                      mem_rdy_i;
    logic                      mem_req_o;
    logic                      mem_we_o;
    dcache_pkg::addr_t         mem_addr_o;
    dcache_pkg::line_t         mem_wdata_o;
    logic                      mem_rvalid_i;
    dcache_pkg::line_t         mem_rdata_i;
    dcache_pkg::cache_state_t  dut_state;

    // architectural image, memory contents and lines stored since their last write-back
    dcache_pkg::word_t ref_words [dcache_pkg::addr_t];
    dcache_pkg::line_t mem_lines [dcache_pkg::addr_t];
    bit                pending   [dcache_pkg::addr_t];
    bit                touched   [dcache_pkg::addr_t];

    dcache_pkg::strb_t legal_strb [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                          4'b0011, 4'b1100, 4'b1111};

    int  errors;
    int  checks;
    int  loads;
    int  stores;
    int  requests;
    int  ok_count;
    int  mem_reads;
    int  mem_writes;
    bit  running;
    bit  stuck;

    dcache_top DUT (.*);

    assign dut_state = DUT.u_ctrl.state;

    always #10 clk = ~clk;

    function automatic dcache_pkg::word_t init_word(dcache_pkg::addr_t a);
        return (a ^ 32'h5a5a_0f0f) * 32'h9e37_79b1 + {a[15:0], a[31:16]};
    endfunction

    function automatic dcache_pkg::word_t ref_word(dcache_pkg::addr_t a);
        if (ref_words.exists(a)) begin
            return ref_words[a];
        end
        return init_word(a);
    endfunction

    function automatic dcache_pkg::line_t image_line(dcache_pkg::addr_t la);
        dcache_pkg::line_t l;
        for (int i = 0; i < 4; i++) begin
            l[i * 32 +: 32] = ref_word(la + 4 * i);
        end
        return l;
    endfunction

    function automatic dcache_pkg::line_t mem_line(dcache_pkg::addr_t la);
        dcache_pkg::line_t l;
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (int i = 0; i < 4; i++) begin
            l[i * 32 +: 32] = init_word(la + 4 * i);
        end
        return l;
    endfunction

    task automatic compare_word(string name, dcache_pkg::word_t got, dcache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_line(string name, dcache_pkg::line_t got, dcache_pkg::line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("errors %0d checks %0d loads %0d stores %0d oks %0d reads %0d writes %0d",
                 errors, checks, loads, stores, ok_count, mem_reads, mem_writes);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // starts at posedge + 1 with the cache idle and returns there after data_ok_o
    task automatic access(input dcache_pkg::addr_t a, input dcache_pkg::strb_t s,
                          input dcache_pkg::word_t d, output dcache_pkg::word_t r,
                          output int lat);
        valid_i = 1'b1;
        addr_i  = a;
        wstrb_i = s;
        wdata_i = d;
        requests++;
        @(posedge clk);
        #1;
        valid_i = 1'b0;
        wstrb_i = '0;
        lat     = 1;
        @(negedge clk);
        while (!data_ok_o && !stuck) begin
            if (lat >= WAIT_LIMIT) begin
                errors++;
                $display("no data_ok_o for request to %h, cache stuck in %s",
                         a, dut_state.name());
                stuck = 1'b1;
            end else begin
                lat++;
                @(negedge clk);
            end
        end
        r = rdata_o;
        if (!stuck) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic do_load(input dcache_pkg::addr_t a, output int lat);
        dcache_pkg::word_t r;
        access(a, '0, '0, r, lat);
        if (!stuck) begin
            compare_word("rdata_o", r, ref_word(a));
        end
        loads++;
    endtask

    task automatic do_store(dcache_pkg::addr_t a, dcache_pkg::strb_t s, dcache_pkg::word_t d);
        dcache_pkg::word_t r;
        dcache_pkg::word_t w;
        int                lat;
        access(a, s, d, r, lat);
        w = ref_word(a);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                w[b * 8 +: 8] = d[b * 8 +: 8];
            end
        end
        ref_words[a] = w;
        pending[a & ~32'hf] = 1'b1;
        touched[a] = 1'b1;
        stores++;
    endtask

    always @(negedge clk) begin
        if (running) begin
            if (data_ok_o) begin
                ok_count++;
            end else if (rdata_o !== '0) begin
                compare_word("rdata_o", rdata_o, '0);
            end
        end
    end

    // line-wide memory with random back-pressure and read latency
    initial begin : memory_model
        dcache_pkg::addr_t la;
        logic              is_read;
        int                delay;
        int                hold;
        mem_rdy_i    = 1'b1;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req_o && mem_rdy_i) begin
                la      = mem_addr_o & ~32'hf;
                is_read = !mem_we_o;
                if (mem_addr_o[dcache_pkg::OFFSET_WIDTH-1:0] != '0) begin
                    errors++;
                    $display("memory request address %h is not line aligned", mem_addr_o);
                end
                if (is_read) begin
                    mem_reads++;
                    if (pending.exists(la)) begin
                        errors++;
                        $display("memory read of line %h issued before its write-back", la);
                    end
                end else begin
                    mem_writes++;
                    compare_line("mem_wdata_o", mem_wdata_o, image_line(la));
                    mem_lines[la] = mem_wdata_o;
                    if (pending.exists(la)) begin
                        pending.delete(la);
                    end
                end
                delay = $urandom_range(1, 6);
                hold  = $urandom_range(0, 3);
                @(posedge clk);
                #1;
                if (is_read) begin
                    mem_rdy_i = 1'b0;
                    repeat (delay - 1) begin
                        @(posedge clk);
                        #1;
                    end
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i  = mem_line(la);
                    @(posedge clk);
                    #1;
                    mem_rvalid_i = 1'b0;
                    mem_rdata_i  = '0;
                end
                mem_rdy_i = (hold == 0);
                repeat (hold) begin
                    @(posedge clk);
                    #1;
                end
                mem_rdy_i = 1'b1;
            end
        end
    end

    initial begin : main_flow
        dcache_pkg::addr_t a;
        int                lat;
        int                polls;
        int unsigned       seed;
        seed = 32'hc320e808;
        void'($urandom(seed));
        clk     = 1'b0;
        rst     = 1'b1;
        valid_i = 1'b0;
        addr_i  = '0;
        wstrb_i = '0;
        wdata_i = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // tag sweep keeps the cache busy after reset
        polls = 0;
        @(negedge clk);
        while (DUT.u_ctrl.sweep_q && !stuck) begin
            if (polls >= WAIT_LIMIT) begin
                errors++;
                $display("tag sweep did not finish after reset");
                stuck = 1'b1;
            end else begin
                polls++;
                @(negedge clk);
            end
        end
        if (!stuck) begin
            @(posedge clk);
            #1;
            running = 1'b1;
        end
        for (int n = 0; n < N_OPS && !stuck; n++) begin
            a = BASE_ADDR + $urandom_range(0, 63) * 16 + $urandom_range(0, 3) * 4;
            if ($urandom_range(0, 1) == 0) begin
                do_load(a, lat);
                touched[a] = 1'b1;
                if ($urandom_range(0, 3) == 0 && !stuck) begin
                    do_load(a, lat);
                    if (!stuck && lat != 1) begin
                        errors++;
                        $display("repeated load to %h answered after %0d cycles", a, lat);
                    end
                end
            end else begin
                do_store(a, legal_strb[$urandom_range(0, 6)], $urandom);
            end
        end
        foreach (touched[t]) begin
            if (!stuck) begin
                do_load(t, lat);
            end
        end
        if (!stuck && ok_count != requests) begin
            errors++;
            $display("saw %0d data_ok_o pulses for %0d requests", ok_count, requests);
        end
        finish_run();
    end

endmodule

// File: project.f
logic/dcache_pkg.sv
logic/lfsr.sv
logic/cache_ram.sv
logic/store_merge.sv
logic/wb_buffer.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
bench/tb_dcache.sv
